/* project.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/writeback_stage.sv
verilog/mem_wb_top.sv
tests/mem_wb_properties.sv
tests/mem_wb_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module mem_wb_tb \
    -o mem_wb_sim

# The run may stop early on an assertion, the output decides
out=$(./obj_dir/mem_wb_sim 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Simulation completed successfully"

/* tests/mem_wb_properties.sv */
`timescale 1ns/1ps

module mem_wb_properties (
    input logic              clk,
    input logic              rst,
    input mem_pkg::apb_req_t apb_req,
    input mem_pkg::apb_rsp_t apb_rsp,
    input logic              ex_ready
);

    // Access phase only ever follows a cycle with psel
    penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> (apb_req.psel && $past(apb_req.psel)))
        else $error("APB penable high without psel or a preceding setup cycle");

    // Setup phase lasts exactly one cycle
    setup_then_access: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && !apb_req.penable) |=> (apb_req.psel && apb_req.penable))
        else $error("APB setup phase not followed by access phase");

    addr_data_stable: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && !apb_rsp.pready) |=>
            ($stable(apb_req.paddr) && $stable(apb_req.pwdata)))
        else $error("APB paddr or pwdata changed during a transfer");

    // Input stays blocked until the RAM responds
    busy_blocks_input: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && !apb_rsp.pready) |=> !ex_ready)
        else $error("ex_ready high before the APB transfer completed");

endmodule

bind mem_stage mem_wb_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .ex_ready (ex_ready)
);

/* tests/mem_wb_tb.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_wb_tb;

    localparam int CLK_HALF        = 2;
    localparam int WAIT_LIMIT      = 20;    // Cycles allowed for one transfer
    localparam int INSTR_BUDGET    = 48;    // Upper bound on issued instructions
    localparam int WATCHDOG_CYCLES = INSTR_BUDGET * (4 + `MEM_WAIT_STATES) + 300;
    localparam int RAM_BYTES       = 4 * `MEM_RAM_WORDS;

    typedef struct packed {
        logic [`MEM_REG_W-1:0]  rd;
        logic [`MEM_DATA_W-1:0] data;
        logic [31:0]            cycle;      // Expected sampling cycle or zero when untimed
    } wr_exp_t;

    logic                   clk;
    logic                   rst;
    mem_pkg::ex_mem_t       ex;
    logic                   ex_valid;
    logic                   ex_ready;
    mem_pkg::rf_write_t     rf;
    logic                   mem_error;
    logic                   mem_done;

    logic [31:0]            cycle = '0;
    integer                 seed = 32'h3036;
    logic [`MEM_DATA_W-1:0] ram_model [int];   // Word index to expected contents
    wr_exp_t                exp_q [$];
    wr_exp_t                head;
    logic [`MEM_DATA_W-1:0] st_addr [8];
    string                  cur_test = "reset";
    int                     errors = 0;
    int                     test_errs0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     done_seen;
    int                     err_seen;
    int                     done_exp;
    int                     err_exp;

    mem_wb_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .ex        (ex),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .rf        (rf),
        .mem_error (mem_error),
        .mem_done  (mem_done)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // Scoreboard samples outputs just before each edge
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (mem_done)
                done_seen++;
            if (mem_error)
                err_seen++;
            if (rf.we && exp_q.size() == 0)
            begin
                $display("Unexpected register write to r%0d in %s", rf.rd, cur_test);
                errors++;
            end
            else if (rf.we)
            begin
                head = exp_q.pop_front();
                check("rd", 32'(head.rd), 32'(rf.rd));
                check("data", head.data, rf.data);
                if (head.cycle != 0)
                    check("write cycle", head.cycle, cycle);
            end
        end
    end

    function automatic mem_pkg::ex_mem_t make_instr(
        input mem_pkg::mem_op_e op,
        input logic rw, input logic m2r, input logic lnk, input logic [4:0] rd,
        input logic [31:0] alu, input logic [31:0] sd, input logic [31:0] la
    );
        mem_pkg::ex_mem_t e;
        e.op         = op;
        e.reg_write  = rw;
        e.mem_to_reg = m2r;
        e.link       = lnk;
        e.rd         = rd;
        e.alu_result = alu;
        e.store_data = sd;
        e.link_addr  = la;
        return e;
    endfunction

    // Reference model of the write rules in acceptance order
    task automatic model_accept(input mem_pkg::ex_mem_t e);
        logic                   err;
        logic [`MEM_DATA_W-1:0] ld;
        wr_exp_t                w;
        int                     idx;
        err = 1'b0;
        ld  = '0;
        idx = int'(e.alu_result >> 2);
        if (e.op != mem_pkg::op_none)
        begin
            done_exp++;
            err = (e.alu_result >= RAM_BYTES);
            if (err)
                err_exp++;
            else if (e.op == mem_pkg::op_store)
                ram_model[idx] = e.store_data;
            else if (ram_model.exists(idx))
                ld = ram_model[idx];
        end
        if (e.reg_write && e.rd != 0 && !err)
        begin
            w.rd   = e.rd;
            w.data = e.link ? e.link_addr : (e.mem_to_reg ? ld : e.alu_result);
            // Registered one edge after acceptance and seen at the next
            w.cycle = (e.op == mem_pkg::op_none) ? cycle + 2 : 32'd0;
            exp_q.push_back(w);
        end
    endtask

    task automatic issue(input mem_pkg::ex_mem_t e, output int stalls);
        stalls = 0;
        ex       <= e;
        ex_valid <= 1'b1;
        @(posedge clk);
        while (!ex_ready && stalls < WAIT_LIMIT)
        begin
            stalls++;
            @(posedge clk);
        end
        if (!ex_ready)
        begin
            $display("Instruction was never accepted in %s", cur_test);
            errors++;
        end
        else
            model_accept(e);
    endtask

    task automatic drain();
        int n;
        n = 0;
        ex_valid <= 1'b0;
        ex       <= '0;
        while ((exp_q.size() != 0 || !ex_ready) && n < WAIT_LIMIT)
        begin
            n++;
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        if (exp_q.size() != 0)
        begin
            $display("Expected register writes never arrived in %s", cur_test);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs0 = errors;
        done_seen  = 0;
        err_seen   = 0;
        done_exp   = 0;
        err_exp    = 0;
    endtask

    task automatic finish_test();
        check("mem_done count", done_exp, done_seen);
        check("mem_error count", err_exp, err_seen);
        tests_run++;
        if (errors != test_errs0)
            tests_failed++;
        $display("%-14s %s (%0d errors)", cur_test,
                 (errors != test_errs0) ? "FAIL" : "ok", errors - test_errs0);
    endtask

    task automatic reset_state();
        start_test("reset_state");
        check("ex_ready", 1, ex_ready);
        check("rf.we", 0, rf.we);
        check("mem_error", 0, mem_error);
        check("mem_done", 0, mem_done);
        check("psel", 0, dut_i.mem_stage_i.apb_req.psel);
        check("penable", 0, dut_i.mem_stage_i.apb_req.penable);
        finish_test();
    endtask

    task automatic alu_writeback();
        int stalls;
        start_test("alu_writeback");
        for (int i = 1; i <= 4; i++)
        begin
            issue(make_instr(mem_pkg::op_none, 1, 0, 0, 5'(i), 32'h100 * i + i, 0, 0), stalls);
            check("stall cycles", 0, stalls);                  // No back-pressure
        end
        issue(make_instr(mem_pkg::op_none, 1, 0, 1, 5'd31, 32'hdead0000, 0, 32'h404), stalls);
        drain();
        finish_test();
    endtask

    task automatic store_then_load();
        int stalls;
        start_test("store_then_load");
        for (int i = 0; i < 8; i++)
        begin
            st_addr[i] = 32'(((i * 37 + 5) % `MEM_RAM_WORDS) * 4);   // Distinct words
            issue(make_instr(mem_pkg::op_store, 0, 0, 0, 0, st_addr[i], $random(seed), 0),
                  stalls);
        end
        for (int i = 7; i >= 0; i--)
            issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'(i + 1), st_addr[i], 0, 0), stalls);
        drain();
        finish_test();
    endtask

    task automatic back_pressure();
        int stalls;
        start_test("back_pressure");
        issue(make_instr(mem_pkg::op_store, 0, 0, 0, 0, 32'h3f0, $random(seed), 0), stalls);
        issue(make_instr(mem_pkg::op_none, 1, 0, 0, 5'd6, 32'h600d0006, 0, 0), stalls);
        check("stall after store", 2 + `MEM_WAIT_STATES, stalls);
        issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'd7, 32'h3f0, 0, 0), stalls);
        check("stall after alu", 0, stalls);
        issue(make_instr(mem_pkg::op_none, 1, 0, 0, 5'd8, 32'h600d0008, 0, 0), stalls);
        check("stall after load", 2 + `MEM_WAIT_STATES, stalls);
        drain();
        finish_test();
    endtask

    task automatic reg0_no_write();
        int stalls;
        start_test("reg0_no_write");
        issue(make_instr(mem_pkg::op_none, 1, 0, 0, 5'd0, 32'h11111111, 0, 0), stalls);
        issue(make_instr(mem_pkg::op_none, 0, 0, 0, 5'd3, 32'h22222222, 0, 0), stalls);
        issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'd0, st_addr[2], 0, 0), stalls);
        issue(make_instr(mem_pkg::op_none, 1, 0, 1, 5'd0, 0, 0, 32'h808), stalls);
        issue(make_instr(mem_pkg::op_none, 1, 0, 0, 5'd9, 32'h99999999, 0, 0), stalls);
        drain();
        finish_test();
    endtask

    task automatic out_of_range();
        int stalls;
        start_test("out_of_range");
        issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'd10, RAM_BYTES, 0, 0), stalls);
        issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'd11, 32'hfffffffc, 0, 0), stalls);
        // Aliases the low index bits of a word stored earlier
        issue(make_instr(mem_pkg::op_store, 0, 0, 0, 0, RAM_BYTES + st_addr[0], 32'hbad0bad0, 0),
              stalls);
        issue(make_instr(mem_pkg::op_load, 1, 1, 0, 5'd12, st_addr[0], 0, 0), stalls);
        drain();
        finish_test();
    endtask

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex       = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_state();
        alu_writeback();
        store_then_load();
        back_pressure();
        reg0_no_write();
        out_of_range();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_ram (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::apb_req_t apb_req,
    output mem_pkg::apb_rsp_t apb_rsp
);

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
    localparam int CNT_W = (`MEM_WAIT_STATES > 0) ? $clog2(`MEM_WAIT_STATES + 1) : 1;
    localparam logic [`MEM_DATA_W-1:0] RAM_BYTES = `MEM_DATA_W'(4 * `MEM_RAM_WORDS);

    logic [`MEM_DATA_W-1:0] mem [`MEM_RAM_WORDS];
    logic [CNT_W-1:0]       wait_cnt;
    logic [IDX_W-1:0]       idx;
    logic                   access;
    logic                   ready;
    logic                   in_range;

    assign idx      = apb_req.paddr[IDX_W+1:2];           // Word index
    assign in_range = (apb_req.paddr < RAM_BYTES);
    assign access   = apb_req.psel && apb_req.penable;
    assign ready    = access && (wait_cnt == CNT_W'(`MEM_WAIT_STATES));

    assign apb_rsp.pready  = ready;
    assign apb_rsp.pslverr = ready && !in_range;          // Only meaningful with pready
    assign apb_rsp.prdata  = (ready && in_range) ? mem[idx] : '0;

    // Counts access cycles until the response
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            wait_cnt <= '0;
        else if (access && !ready)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (ready && apb_req.pwrite && in_range)
            mem[idx] <= apb_req.pwdata;                   // Out of range writes dropped
    end

endmodule

/* verilog/mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_setup  = 2'd1,
        st_access = 2'd2
    } mem_state_e;

    typedef struct packed {
        mem_op_e                 op;
        logic                    reg_write;
        logic                    mem_to_reg;
        logic                    link;        // Write link_addr instead of result
        logic [`MEM_REG_W-1:0]   rd;
        logic [`MEM_DATA_W-1:0]  alu_result;  // Also the byte address
        logic [`MEM_DATA_W-1:0]  store_data;
        logic [`MEM_DATA_W-1:0]  link_addr;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        logic                    mem_to_reg;
        logic                    link;
        logic [`MEM_REG_W-1:0]   rd;
        logic [`MEM_DATA_W-1:0]  alu_result;
        logic [`MEM_DATA_W-1:0]  load_data;
        logic [`MEM_DATA_W-1:0]  link_addr;
        logic                    err;         // Slave error on the access
    } mem_wb_t;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`MEM_DATA_W-1:0]  paddr;
        logic [`MEM_DATA_W-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                    pready;
        logic [`MEM_DATA_W-1:0]  prdata;
        logic                    pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                    we;
        logic [`MEM_REG_W-1:0]   rd;
        logic [`MEM_DATA_W-1:0]  data;
    } rf_write_t;

endpackage

/* verilog/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data path and address width
`define MEM_DATA_W 32

// Data RAM depth in 32-bit words
`define MEM_RAM_WORDS 256

// Extra access cycles before pready
`define MEM_WAIT_STATES 1

// Register file index width
`define MEM_REG_W 5

`endif

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::ex_mem_t  ex,
    input  logic              ex_valid,
    output logic              ex_ready,
    output mem_pkg::apb_req_t apb_req,
    input  mem_pkg::apb_rsp_t apb_rsp,
    output mem_pkg::mem_wb_t  mw,
    output logic              mw_valid,
    output logic              mem_done
);

    mem_pkg::mem_state_e      state;
    mem_pkg::ex_mem_t         ex_q;      // Instruction held for the APB transfer
    logic                     accept;
    logic                     is_mem;
    logic                     finish;
    logic [`MEM_DATA_W-1:0]   rd_data;

    function automatic mem_pkg::mem_wb_t make_mw(
        input mem_pkg::ex_mem_t       e,
        input logic [`MEM_DATA_W-1:0] ld,
        input logic                   err
    );
        mem_pkg::mem_wb_t r;
        r.reg_write  = e.reg_write;
        r.mem_to_reg = e.mem_to_reg;
        r.link       = e.link;
        r.rd         = e.rd;
        r.alu_result = e.alu_result;
        r.load_data  = ld;
        r.link_addr  = e.link_addr;
        r.err        = err;
        return r;
    endfunction

    assign ex_ready = (state == mem_pkg::st_idle);   // Busy through the whole APB transfer
    assign accept   = ex_valid && ex_ready;
    assign is_mem   = (ex.op == mem_pkg::op_load) || (ex.op == mem_pkg::op_store);
    assign finish   = (state == mem_pkg::st_access) && apb_rsp.pready;

    // Stores read back nothing useful
    assign rd_data  = (ex_q.op == mem_pkg::op_load) ? apb_rsp.prdata : '0;

    // Request comes straight from the held instruction, stable across the transfer
    assign apb_req.psel    = (state != mem_pkg::st_idle);
    assign apb_req.penable = (state == mem_pkg::st_access);
    assign apb_req.pwrite  = (ex_q.op == mem_pkg::op_store);
    assign apb_req.paddr   = ex_q.alu_result;
    assign apb_req.pwdata  = ex_q.store_data;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= mem_pkg::st_idle;
            mw_valid <= 1'b0;
            mem_done <= 1'b0;
        end
        else
        begin
            mw_valid <= 1'b0;                // Single-cycle pulses
            mem_done <= 1'b0;
            case (state)
                mem_pkg::st_idle:
                begin
                    if (accept)
                    begin
                        if (is_mem)
                            state <= mem_pkg::st_setup;
                        else
                            mw_valid <= 1'b1;    // Bypass, straight to write-back
                    end
                end
                mem_pkg::st_setup:
                    state <= mem_pkg::st_access;
                mem_pkg::st_access:
                begin
                    if (apb_rsp.pready)
                    begin
                        state    <= mem_pkg::st_idle;
                        mw_valid <= 1'b1;
                        mem_done <= 1'b1;
                    end
                end
                default:
                    state <= mem_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            ex_q <= ex;
        if (accept && !is_mem)
            mw <= make_mw(ex, '0, 1'b0);
        else if (finish)
            mw <= make_mw(ex_q, rd_data, apb_rsp.pslverr);
    end

endmodule

/* verilog/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::ex_mem_t   ex,
    input  logic               ex_valid,
    output logic               ex_ready,
    output mem_pkg::rf_write_t rf,
    output logic               mem_error,
    output logic               mem_done
);

    mem_pkg::apb_req_t apb_req;     // Memory stage to RAM
    mem_pkg::apb_rsp_t apb_rsp;
    mem_pkg::mem_wb_t  mw;          // Memory stage to write-back
    logic              mw_valid;

    mem_stage mem_stage_i (
        .clk      (clk),
        .rst      (rst),
        .ex       (ex),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .mw       (mw),
        .mw_valid (mw_valid),
        .mem_done (mem_done)
    );

    data_ram data_ram_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    writeback_stage writeback_stage_i (
        .clk       (clk),
        .rst       (rst),
        .mw        (mw),
        .mw_valid  (mw_valid),
        .rf        (rf),
        .mem_error (mem_error)
    );

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module writeback_stage (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::mem_wb_t    mw,
    input  logic                mw_valid,
    output mem_pkg::rf_write_t  rf,
    output logic                mem_error
);

    logic                   we_q;
    logic [`MEM_REG_W-1:0]  rd_q;
    logic [`MEM_DATA_W-1:0] data_q;
    logic [`MEM_DATA_W-1:0] wb_data;
    logic                   wb_we;

    // Link wins over a load result
    always_comb
    begin
        if (mw.link)
            wb_data = mw.link_addr;
        else if (mw.mem_to_reg)
            wb_data = mw.load_data;
        else
            wb_data = mw.alu_result;
    end

    assign wb_we = mw_valid && mw.reg_write && !mw.err && (mw.rd != '0);   // r0 stays zero

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            we_q      <= 1'b0;
            mem_error <= 1'b0;
        end
        else
        begin
            we_q      <= wb_we;
            mem_error <= mw_valid && mw.err;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mw_valid)
        begin
            rd_q   <= mw.rd;
            data_q <= wb_data;
        end
    end

    assign rf.we   = we_q;
    assign rf.rd   = rd_q;
    assign rf.data = data_q;

endmodule
